//--- Makefile
VERILATOR ?= verilator
TOP       := tb_pq
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal
RUNFLAGS  := +verilator+error+limit+1000
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/pq_if.sv
`default_nettype none
`timescale 1ns/1ps

// Command path between front end and array
interface pq_op_if import pq_pkg::*; ();
  logic    push;   // Insert strobe
  logic    pop;    // Remove strobe, with push means replace
  pq_key_t key;    // Key for insert or replace
  logic    full;   // Level
  logic    empty;  // Level
  pq_key_t head;   // Largest stored key
  pq_cnt_t occ;    // Stored key count

  modport ctrl (
    output push, pop, key,
    input  full, empty
  );

  modport array (
    input  push, pop, key,
    output full, empty, head, occ
  );
endinterface

// Refusal events, one-cycle pulses
interface pq_evt_if ();
  logic ovf;  // Insert refused while full
  logic unf;  // Remove refused while empty

  modport ctrl (output ovf, unf);
  modport stat (input ovf, unf);
endinterface

`default_nettype wire

//--- common/pq_pkg.sv
`default_nettype none

package pq_pkg;

  // --------------------
  // Sizing
  // --------------------
  localparam int PQ_DEPTH   = 8;                     // Slot count, must be even
  localparam int PQ_WIDTH   = 16;                    // Key bits
  localparam int PQ_PAIRS   = PQ_DEPTH / 2;          // Compare-exchange pairs
  localparam int CNT_WIDTH  = $clog2(PQ_DEPTH) + 1;  // Holds 0 .. PQ_DEPTH
  localparam int STAT_WIDTH = 16;                    // Event counter bits

  // --------------------
  // Types
  // --------------------
  typedef logic [PQ_WIDTH-1:0]   pq_key_t;   // Zero marks an empty slot
  typedef logic [CNT_WIDTH-1:0]  pq_cnt_t;   // Occupancy
  typedef logic [STAT_WIDTH-1:0] pq_stat_t;  // Saturating event count

  // Statistics register map
  typedef enum logic [1:0] {
    REG_OCC = 2'd0,  // Current occupancy
    REG_OVF = 2'd1,  // Refused inserts while full
    REG_UNF = 2'd2,  // Refused removes while empty
    REG_HWM = 2'd3   // Peak occupancy
  } pq_reg_addr_e;

endpackage

`default_nettype wire

//--- hw/pq_cmd_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module pq_cmd_ctrl import pq_pkg::*; (
  // Raw command strobes
  input  var logic    i_push,  // Insert request
  input  var logic    i_pop,   // Remove request
  input  var pq_key_t i_key,   // Key to store
  // Legal command to array
  pq_op_if.ctrl       op,
  // Refusal pulses to statistics
  pq_evt_if.ctrl      evt
);

  // --------------------
  // Request cleanup
  // --------------------
  logic key_ok;    // Nonzero key
  logic want_ins;  // Insert half of the command survives
  logic want_rem;  // Remove half of the command

  assign key_ok   = (i_key != '0);
  assign want_ins = i_push && key_ok;  // Zero key drops the insert half
  assign want_rem = i_pop;
  assign op.key   = i_key;             // Key passes straight through

  // --------------------
  // Legality
  // --------------------
  always_comb begin : legal_chk
    op.push = 1'b0;
    op.pop  = 1'b0;
    evt.ovf = 1'b0;
    evt.unf = 1'b0;
    case ({want_ins, want_rem})
      2'b10: begin  // Insert
        if (op.full) begin
          evt.ovf = 1'b1;  // Dropped, no room
        end else begin
          op.push = 1'b1;
        end
      end
      2'b01: begin  // Remove, or replace with zero key
        if (op.empty) begin
          evt.unf = 1'b1;  // Dropped, nothing to discard
        end else begin
          op.pop = 1'b1;
        end
      end
      2'b11: begin  // Replace
        op.push = 1'b1;
        op.pop  = !op.empty;  // Empty queue turns it into an insert
      end
      default: begin
        // Idle or zero-key insert
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pq_stat_regs.sv
`default_nettype none
`timescale 1ns/1ps

module pq_stat_regs import pq_pkg::*; (
  input  var logic                  i_CLK,        // Clock
  input  var logic                  i_RSTn,       // Async reset, active low
  input  var pq_cnt_t               i_occ,        // Occupancy from array
  pq_evt_if.stat                    evt,          // Refusal pulses
  input  var logic                  i_stat_clr,   // Clear counters
  input  var pq_reg_addr_e          i_reg_addr,   // Register select
  output var logic [STAT_WIDTH-1:0] o_reg_rdata   // Selected value
);

  // --------------------
  // Counters
  // --------------------
  pq_stat_t ovf_cnt_q;  // Saturating
  pq_stat_t unf_cnt_q;  // Saturating
  pq_cnt_t  hwm_q;      // Peak seen up to last edge
  pq_cnt_t  hwm_now;    // Peak including current occupancy

  // Current occupancy counts toward the peak right away
  assign hwm_now = (i_occ > hwm_q) ? i_occ : hwm_q;

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      ovf_cnt_q <= '0;
      unf_cnt_q <= '0;
      hwm_q     <= '0;
    end else if (i_stat_clr) begin  // Wins over same-cycle events
      ovf_cnt_q <= '0;
      unf_cnt_q <= '0;
      hwm_q     <= i_occ;           // Restart peak from present level
    end else begin
      if (evt.ovf && (ovf_cnt_q != '1)) begin
        ovf_cnt_q <= ovf_cnt_q + 1'b1;
      end
      if (evt.unf && (unf_cnt_q != '1)) begin
        unf_cnt_q <= unf_cnt_q + 1'b1;
      end
      hwm_q <= hwm_now;
    end
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb begin : rd_mux
    case (i_reg_addr)
      REG_OCC: o_reg_rdata = pq_stat_t'(i_occ);    // Zero-extended
      REG_OVF: o_reg_rdata = ovf_cnt_q;
      REG_UNF: o_reg_rdata = unf_cnt_q;
      REG_HWM: o_reg_rdata = pq_stat_t'(hwm_now);  // Zero-extended
      default: o_reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pq_top.sv
`default_nettype none
`timescale 1ns/1ps

module pq_top import pq_pkg::*; (
  input  var logic       i_CLK,        // Clock
  input  var logic       i_RSTn,       // Async reset, active low
  // Commands
  input  var logic       i_push,       // Insert strobe
  input  var logic       i_pop,        // Remove strobe
  input  var pq_key_t    i_key,        // Key for insert or replace
  // Queue status
  output var pq_key_t    o_head,       // Largest key, 0 when empty
  output var logic       o_full,
  output var logic       o_empty,
  // Statistics access
  input  var logic [1:0] i_reg_addr,   // See pq_reg_addr_e
  input  var logic       i_stat_clr,   // Clear pulse
  output var pq_stat_t   o_reg_rdata   // Combinational read
);

  pq_op_if  op_bus ();
  pq_evt_if evt_bus ();

  // --------------------
  // Front end
  // --------------------
  pq_cmd_ctrl u_cmd_ctrl (
    .i_push (i_push),
    .i_pop  (i_pop),
    .i_key  (i_key),
    .op     (op_bus.ctrl),
    .evt    (evt_bus.ctrl)
  );

  // Storage and sort network
  pq_register_array u_array (
    .i_CLK  (i_CLK),
    .i_RSTn (i_RSTn),
    .op     (op_bus.array)
  );

  // Side register block
  pq_stat_regs u_stat (
    .i_CLK       (i_CLK),
    .i_RSTn      (i_RSTn),
    .i_occ       (op_bus.occ),
    .evt         (evt_bus.stat),
    .i_stat_clr  (i_stat_clr),
    .i_reg_addr  (pq_reg_addr_e'(i_reg_addr)),
    .o_reg_rdata (o_reg_rdata)
  );

  assign o_head  = op_bus.head;
  assign o_full  = op_bus.full;
  assign o_empty = op_bus.empty;

endmodule

`default_nettype wire

//--- register_array/pq_register_array.sv
`default_nettype none
`timescale 1ns/1ps

module pq_register_array import pq_pkg::*; (
  input var logic i_CLK,   // Clock
  input var logic i_RSTn,  // Async reset, active low
  pq_op_if.array  op       // Legal commands in, status out
);

  // --------------------
  // Storage
  // --------------------
  pq_key_t slot_q   [PQ_DEPTH];  // Slot 0 is the head
  pq_key_t slot_mod [PQ_DEPTH];  // After the command is applied
  pq_key_t slot_d   [PQ_DEPTH];  // After both exchange stages
  pq_key_t pair_hi  [PQ_PAIRS];  // Larger of each even/odd pair
  pq_key_t pair_lo  [PQ_PAIRS];  // Smaller of each even/odd pair
  pq_cnt_t occ_q;
  pq_cnt_t occ_d;

  logic do_ins;  // Insert only
  logic do_rem;  // Remove only
  logic do_rep;  // Both strobes

  assign do_ins = op.push && !op.pop;
  assign do_rem = !op.push && op.pop;
  assign do_rep = op.push && op.pop;

  // Status straight from registers
  assign op.head  = slot_q[0];
  assign op.occ   = occ_q;
  assign op.full  = (occ_q == pq_cnt_t'(PQ_DEPTH));
  assign op.empty = (occ_q == '0);

  // --------------------
  // Command apply
  // --------------------
  always_comb begin : cmd_apply
    logic carry;  // No hole met yet
    slot_mod = slot_q;
    carry    = 1'b1;
    if (do_ins) begin
      for (int i = 1; i < PQ_DEPTH; i++) begin
        carry = carry && (slot_q[i-1] != '0);
        if (carry) begin
          slot_mod[i] = slot_q[i-1];  // Shift toward tail, first hole absorbs it
        end
      end
      slot_mod[0] = op.key;
    end else if (do_rem) begin
      slot_mod[0] = '0;  // Hole at head, refilled below
    end else if (do_rep) begin
      slot_mod[0] = op.key;  // Old head discarded
    end
  end

  // Stage 1, pairwise max/min on (0,1) (2,3) ...
  always_comb begin : pair_stage
    for (int p = 0; p < PQ_PAIRS; p++) begin
      if (slot_mod[2*p] >= slot_mod[2*p+1]) begin
        pair_hi[p] = slot_mod[2*p];
        pair_lo[p] = slot_mod[2*p+1];
      end else begin
        pair_hi[p] = slot_mod[2*p+1];
        pair_lo[p] = slot_mod[2*p];
      end
    end
  end

  // Stage 2, offset exchange on (1,2) (3,4) ...
  always_comb begin : offset_stage
    slot_d[0]          = pair_hi[0];           // Maximum lands at head
    slot_d[PQ_DEPTH-1] = pair_lo[PQ_PAIRS-1];  // Tail has no right partner
    for (int p = 0; p < PQ_PAIRS - 1; p++) begin
      if (pair_lo[p] >= pair_hi[p+1]) begin
        slot_d[2*p+1] = pair_lo[p];
        slot_d[2*p+2] = pair_hi[p+1];
      end else begin
        slot_d[2*p+1] = pair_hi[p+1];  // Larger moves toward head
        slot_d[2*p+2] = pair_lo[p];
      end
    end
  end

  // --------------------
  // Occupancy
  // --------------------
  always_comb begin : occ_next
    occ_d = occ_q;
    if (do_ins) begin
      occ_d = occ_q + 1'b1;
    end else if (do_rem) begin
      occ_d = occ_q - 1'b1;
    end
    // Replace keeps the count
  end

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      slot_q <= '{default: '0};  // All slots empty
      occ_q  <= '0;
    end else begin
      slot_q <= slot_d;
      occ_q  <= occ_d;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
common/pq_pkg.sv
common/pq_if.sv
hw/pq_cmd_ctrl.sv
register_array/pq_register_array.sv
hw/pq_stat_regs.sv
hw/pq_top.sv
sim/pq_checker.sv
sim/pq_monitor.sv
sim/tb_pq.sv

//--- sim/pq_checker.sv
`default_nettype none
`timescale 1ns/1ps

module pq_checker import pq_pkg::*; (
  input var logic    i_CLK,    // Clock
  input var logic    i_RSTn,   // Async reset, active low
  input var pq_key_t i_head,   // Head key of the queue
  input var logic    i_full,
  input var logic    i_empty
);

  int fail_cnt = 0;  // Assertion failures so far

  // Flags are mutually exclusive
  a_flags_excl: assert property (@(posedge i_CLK) disable iff (!i_RSTn) !(i_full && i_empty))
    else begin
      fail_cnt++;
      $error("full and empty high together");
    end

  // Zero head only when empty
  a_head_zero: assert property (@(posedge i_CLK) disable iff (!i_RSTn)
    (i_head == '0) == i_empty)
    else begin
      fail_cnt++;
      $error("head and empty flag disagree");
    end

  // First edge out of reset sees an empty queue
  a_reset_flags: assert property (@(posedge i_CLK)
    $rose(i_RSTn) |-> (i_empty && !i_full && (i_head == '0)))
    else begin
      fail_cnt++;
      $error("flags wrong after reset");
    end

endmodule

`default_nettype wire

//--- sim/pq_monitor.sv
`default_nettype none
`timescale 1ns/1ps

module pq_monitor import pq_pkg::*; (
  input var logic       i_CLK,
  input var logic       i_RSTn,
  input var logic       i_push,      // Command inputs as driven
  input var logic       i_pop,
  input var pq_key_t    i_key,
  input var logic       i_stat_clr,
  input var logic [1:0] i_reg_addr,
  input var pq_key_t    i_head,      // DUT outputs
  input var logic       i_full,
  input var logic       i_empty,
  input var pq_stat_t   i_rdata
);

  // --------------------
  // Reference model
  // --------------------
  pq_key_t  keys [$];  // Stored keys, order irrelevant
  pq_stat_t ovf_cnt;
  pq_stat_t unf_cnt;
  int       hwm;       // Peak occupancy incl. current
  int       err_cnt = 0;

  function automatic pq_key_t model_max();
    pq_key_t m;
    m = '0;  // Empty model reads as zero
    foreach (keys[i]) if (keys[i] > m) m = keys[i];
    return m;
  endfunction

  function automatic void remove_max();
    int idx;
    idx = 0;
    foreach (keys[i]) if (keys[i] > keys[idx]) idx = i;
    keys.delete(idx);
  endfunction

  // One command on the previous model state
  function automatic void pq_ref_step(input logic push, input logic pop,
                                      input pq_key_t key, input logic clr);
    logic ins;
    int   occ;
    ins = push && (key != '0);  // Zero key never stored
    occ = keys.size();
    if (clr) begin
      ovf_cnt = '0;
      unf_cnt = '0;
      hwm     = occ;  // Restart from level before the command
    end
    if (ins && !pop) begin
      if (occ == PQ_DEPTH) begin
        if (!clr && (ovf_cnt != '1)) ovf_cnt = ovf_cnt + 1'b1;
      end else keys.push_back(key);
    end else if (!ins && pop) begin
      if (occ == 0) begin
        if (!clr && (unf_cnt != '1)) unf_cnt = unf_cnt + 1'b1;
      end else remove_max();
    end else if (ins && pop) begin
      if (occ != 0) remove_max();  // Replace on empty is an insert
      keys.push_back(key);
    end
    if (keys.size() > hwm) hwm = keys.size();
  endfunction

  function automatic pq_stat_t reg_expect(input logic [1:0] addr);
    case (addr)
      REG_OCC: return pq_stat_t'(keys.size());
      REG_OVF: return ovf_cnt;
      REG_UNF: return unf_cnt;
      default: return pq_stat_t'(hwm);
    endcase
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------
  // Compare process
  // --------------------
  always @(posedge i_CLK or negedge i_RSTn) begin : compare
    if (!i_RSTn) begin
      keys.delete();
      ovf_cnt = '0;
      unf_cnt = '0;
      hwm     = 0;
    end else begin
      pq_ref_step(i_push, i_pop, i_key, i_stat_clr);
      #2;  // Outputs settled, inputs not yet moved
      expect_eq("head", i_head, model_max());
      expect_eq("full", i_full, keys.size() == PQ_DEPTH);
      expect_eq("empty", i_empty, keys.size() == 0);
      expect_eq($sformatf("register %0d", i_reg_addr), i_rdata, reg_expect(i_reg_addr));
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_pq.sv
`default_nettype none
`timescale 1ns/1ps

module tb_pq import pq_pkg::*; ();

  logic       i_CLK, i_RSTn, i_push, i_pop, i_stat_clr;
  pq_key_t    i_key, o_head, key;
  logic [1:0] i_reg_addr;
  logic       o_full, o_empty;
  pq_stat_t   o_reg_rdata;
  logic [31:0] r;
  integer     seed;
  int         err_base = 0, n_tests = 0, n_failed = 0;
  logic       timed_out = 1'b0;

  pq_top dut (.*);

  pq_monitor mon (
    .i_CLK(i_CLK), .i_RSTn(i_RSTn), .i_push(i_push), .i_pop(i_pop),
    .i_key(i_key), .i_stat_clr(i_stat_clr), .i_reg_addr(i_reg_addr),
    .i_head(o_head), .i_full(o_full), .i_empty(o_empty), .i_rdata(o_reg_rdata)
  );

  bind pq_top pq_checker u_chk (
    .i_CLK(i_CLK), .i_RSTn(i_RSTn), .i_head(o_head), .i_full(o_full), .i_empty(o_empty)
  );

  initial begin : clk_gen
    i_CLK = 1'b0;
    forever #4 i_CLK = ~i_CLK;  // 8 ns period
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic pq_key_t rand_key();
    pq_key_t k;
    k = pq_key_t'($random(seed));
    if (k == '0) k = 16'h0001;  // Keep it storable
    return k;
  endfunction

  // Called at a falling edge, holds the command for one cycle
  task automatic drive(input logic push, input logic pop, input pq_key_t k, input logic clr);
    i_push     = push;
    i_pop      = pop;
    i_key      = k;
    i_stat_clr = clr;
    i_reg_addr = i_reg_addr + 2'd1;  // Walk all four registers
    @(negedge i_CLK);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic fill_queue(input string tag);
    for (int n = 0; !o_full && n < 2 * PQ_DEPTH; n++) drive(1'b1, 1'b0, rand_key(), 1'b0);
    if (!o_full) begin
      $display("timeout: queue never reported full in %s", tag);
      timed_out = 1'b1;
    end
  endtask

  task automatic drain_queue(input string tag);
    for (int n = 0; !o_empty && n < 2 * PQ_DEPTH; n++) drive(1'b0, 1'b1, '0, 1'b0);
    if (!o_empty) begin
      $display("timeout: queue never reported empty in %s", tag);
      timed_out = 1'b1;
    end
  endtask

  task automatic report(input string name);
    int errs;
    errs     = mon.err_cnt - err_base;
    err_base = mon.err_cnt;
    n_tests++;
    if (errs != 0) n_failed++;
    $display("test %-8s %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    seed = 32'hf9fc037f;
    {i_RSTn, i_push, i_pop, i_stat_clr} = '0;
    i_key      = '0;
    i_reg_addr = '0;
    repeat (5) @(posedge i_CLK);
    @(negedge i_CLK);
    i_RSTn = 1'b1;
    idle(4);
    report("reset");
    for (int i = 0; i < PQ_DEPTH; i++) begin
      key = (rand_key() & 16'hfff0) | pq_key_t'(i + 1);  // Low nibble keeps them distinct
      drive(1'b1, 1'b0, key, 1'b0);
    end
    idle(4);
    report("fill");
    drain_queue("drain");
    idle(2);
    report("drain");
    repeat (2) drive(1'b0, 1'b1, '0, 1'b0);  // Underflow
    drive(1'b1, 1'b0, '0, 1'b0);             // Zero key ignored
    fill_queue("refused");
    repeat (2) drive(1'b1, 1'b0, rand_key(), 1'b0);  // Overflow
    idle(4);
    report("refused");
    repeat (10) drive(1'b1, 1'b1, rand_key(), 1'b0);  // While full
    repeat (3) drive(1'b0, 1'b1, '0, 1'b0);
    repeat (10) drive(1'b1, 1'b1, rand_key(), 1'b0);  // Partly filled
    drain_queue("replace");
    drive(1'b1, 1'b1, rand_key(), 1'b0);              // Empty, acts as insert
    idle(4);
    report("replace");
    drive(1'b0, 1'b0, '0, 1'b1);
    idle(4);
    repeat (200) begin
      r = $random(seed);
      drive(r[0], r[1], (r[4:2] == 3'd0) ? '0 : rand_key(), r[9:5] == 5'd0);
    end
    idle(4);
    report("stats");
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             n_tests, n_failed, mon.err_cnt, dut.u_chk.fail_cnt);
    if (n_failed == 0 && !timed_out && dut.u_chk.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
